// ==== common/ooo_pkg.sv ====
package ooo_pkg;

    localparam int XLEN      = 32;
    localparam int NUM_REGS  = 32;
    localparam int REG_W     = 5;
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W     = 3;
    localparam int NUM_RS    = 4;

    // immediate field and rob occupancy counter widths
    localparam int IMM_W = 12;
    localparam int CNT_W = 4;

    typedef enum logic [2:0] {
        ADD  = 3'd0,
        SUB  = 3'd1,
        AND  = 3'd2,
        OR   = 3'd3,
        XOR  = 3'd4,
        ADDI = 3'd5,
        XORI = 3'd6
    } alu_op_e;

    typedef struct packed {
        alu_op_e          op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [IMM_W-1:0] imm;
        logic [XLEN-1:0]  pc;
    } dec_op_t;

    // data is only meaningful once ready is set
    typedef struct packed {
        logic             ready;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  data;
    } operand_t;

    typedef struct packed {
        alu_op_e          op;
        logic [IMM_W-1:0] imm;
        logic [TAG_W-1:0] dest_tag;
        operand_t         src1;
        operand_t         src2;
    } rs_entry_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  data;
    } cdb_t;

    typedef struct packed {
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  data;
        logic [XLEN-1:0]  pc;
    } commit_t;

endpackage

// ==== logic/reg_rename_file.sv ====
`timescale 1ns/1ps

module reg_rename_file (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic [ooo_pkg::REG_W-1:0] rd_rs1,
    input  logic [ooo_pkg::REG_W-1:0] rd_rs2,
    output logic                      rs1_busy,
    output logic [ooo_pkg::TAG_W-1:0] rs1_tag,
    output logic [ooo_pkg::XLEN-1:0]  rs1_data,
    output logic                      rs2_busy,
    output logic [ooo_pkg::TAG_W-1:0] rs2_tag,
    output logic [ooo_pkg::XLEN-1:0]  rs2_data,
    input  logic                      rename_en,
    input  logic [ooo_pkg::REG_W-1:0] rename_rd,
    input  logic [ooo_pkg::TAG_W-1:0] rename_tag,
    input  logic                      commit_en,
    input  logic [ooo_pkg::REG_W-1:0] commit_rd,
    input  logic [ooo_pkg::TAG_W-1:0] commit_tag,
    input  logic [ooo_pkg::XLEN-1:0]  commit_value
);
    import ooo_pkg::*;

    logic [XLEN-1:0]     regs [NUM_REGS];
    logic [TAG_W-1:0]    tags [NUM_REGS];
    logic [NUM_REGS-1:0] busy;

    logic rename_hit;
    logic commit_hit;

    // x0 is never written or renamed, so it keeps reading zero
    assign rename_hit = rename_en && (rename_rd != '0);
    assign commit_hit = commit_en && (commit_rd != '0);

    assign rs1_busy = busy[rd_rs1];
    assign rs1_tag  = tags[rd_rs1];
    assign rs1_data = regs[rd_rs1];
    assign rs2_busy = busy[rd_rs2];
    assign rs2_tag  = tags[rd_rs2];
    assign rs2_data = regs[rd_rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (commit_hit) begin
                regs[commit_rd] <= commit_value;
                // only the youngest rename may release the register
                if (tags[commit_rd] == commit_tag) begin
                    busy[commit_rd] <= 1'b0;
                end
            end
            if (flush) begin
                busy <= '0;
            end else if (rename_hit) begin
                busy[rename_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rename_hit) begin
            tags[rename_rd] <= rename_tag;
        end
    end

endmodule

// ==== rob/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      alloc_en,
    input  logic [ooo_pkg::REG_W-1:0] alloc_rd,
    input  logic [ooo_pkg::XLEN-1:0]  alloc_pc,
    output logic                      full,
    output logic [ooo_pkg::TAG_W-1:0] alloc_tag,
    input  ooo_pkg::cdb_t             cdb,
    input  logic [ooo_pkg::TAG_W-1:0] lookup_tag1,
    output logic                      lookup_done1,
    output logic [ooo_pkg::XLEN-1:0]  lookup_data1,
    input  logic [ooo_pkg::TAG_W-1:0] lookup_tag2,
    output logic                      lookup_done2,
    output logic [ooo_pkg::XLEN-1:0]  lookup_data2,
    output logic                      commit_valid,
    output ooo_pkg::commit_t          commit_data,
    output logic [ooo_pkg::TAG_W-1:0] commit_tag,
    input  logic                      commit_ready
);
    import ooo_pkg::*;

    logic [REG_W-1:0]     rd_q   [ROB_DEPTH];
    logic [XLEN-1:0]      pc_q   [ROB_DEPTH];
    logic [XLEN-1:0]      data_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done;

    logic [TAG_W-1:0] head;
    logic [TAG_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             pop;

    assign full      = (count == CNT_W'(ROB_DEPTH));
    assign alloc_tag = tail;

    assign lookup_done1 = done[lookup_tag1];
    assign lookup_data1 = data_q[lookup_tag1];
    assign lookup_done2 = done[lookup_tag2];
    assign lookup_data2 = data_q[lookup_tag2];

    // head entry drives the commit port until accepted
    assign commit_valid     = (count != '0) && done[head];
    assign commit_tag       = head;
    assign commit_data.rd   = rd_q[head];
    assign commit_data.data = data_q[head];
    assign commit_data.pc   = pc_q[head];

    assign pop = commit_valid && commit_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (alloc_en) begin
                done[tail] <= 1'b0;
                tail       <= tail + TAG_W'(1);
            end
            if (cdb.valid) begin
                done[cdb.tag] <= 1'b1;
            end
            if (pop) begin
                head <= head + TAG_W'(1);
            end
            count <= count + CNT_W'(alloc_en) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            rd_q[tail] <= alloc_rd;
            pc_q[tail] <= alloc_pc;
        end
        if (cdb.valid) begin
            data_q[cdb.tag] <= cdb.data;
        end
    end

endmodule

// ==== rs/rs_dispatch.sv ====
`timescale 1ns/1ps

module rs_dispatch (
    input  logic                       in_valid,
    input  ooo_pkg::dec_op_t           in_op,
    input  logic [ooo_pkg::TAG_W-1:0]  alloc_tag,
    input  logic                       rs1_busy,
    input  logic [ooo_pkg::TAG_W-1:0]  rs1_tag,
    input  logic [ooo_pkg::XLEN-1:0]   rs1_data,
    input  logic                       rs2_busy,
    input  logic [ooo_pkg::TAG_W-1:0]  rs2_tag,
    input  logic [ooo_pkg::XLEN-1:0]   rs2_data,
    input  logic                       lookup_done1,
    input  logic [ooo_pkg::XLEN-1:0]   lookup_data1,
    input  logic                       lookup_done2,
    input  logic [ooo_pkg::XLEN-1:0]   lookup_data2,
    input  ooo_pkg::cdb_t              cdb,
    input  logic [ooo_pkg::NUM_RS-1:0] slot_busy,
    output logic [ooo_pkg::NUM_RS-1:0] slot_write,
    output ooo_pkg::rs_entry_t         entry,
    output logic                       have_free
);
    import ooo_pkg::*;

    logic [NUM_RS-1:0] free;
    logic [NUM_RS-1:0] lowest_free;
    logic              imm_form;

    // register file, then broadcast bypass, then finished rob entry
    function automatic operand_t resolve(
        input logic             busy,
        input logic [TAG_W-1:0] tag,
        input logic [XLEN-1:0]  rf_data,
        input logic             done,
        input logic [XLEN-1:0]  rob_data,
        input cdb_t             bus
    );
        operand_t opnd;
        opnd.ready = 1'b1;
        opnd.tag   = tag;
        opnd.data  = rf_data;
        if (busy) begin
            if (bus.valid && (bus.tag == tag)) begin
                opnd.data = bus.data;
            end else if (done) begin
                opnd.data = rob_data;
            end else begin
                opnd.ready = 1'b0;
                opnd.data  = '0;
            end
        end
        return opnd;
    endfunction

    assign free        = ~slot_busy;
    assign lowest_free = free & (~free + NUM_RS'(1));
    assign have_free   = |free;
    assign slot_write  = in_valid ? lowest_free : '0;

    assign imm_form = (in_op.op == ADDI) || (in_op.op == XORI);

    always_comb begin
        entry.op       = in_op.op;
        entry.imm      = in_op.imm;
        entry.dest_tag = alloc_tag;
        entry.src1     = resolve(rs1_busy, rs1_tag, rs1_data, lookup_done1, lookup_data1, cdb);
        if (imm_form) begin
            entry.src2 = '{ready: 1'b1, tag: '0, data: '0};
        end else begin
            entry.src2 = resolve(rs2_busy, rs2_tag, rs2_data, lookup_done2, lookup_data2, cdb);
        end
    end

endmodule

// ==== rs/rs_slot.sv ====
`timescale 1ns/1ps

module rs_slot (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               write,
    input  ooo_pkg::rs_entry_t entry_in,
    input  ooo_pkg::cdb_t      cdb,
    input  logic               grant,
    output logic               busy,
    output logic               ready_to_issue,
    output ooo_pkg::rs_entry_t entry_out
);
    import ooo_pkg::*;

    rs_entry_t held;
    logic      wake1;
    logic      wake2;

    // a waiting operand picks up the broadcast carrying its tag
    assign wake1 = cdb.valid && !held.src1.ready && (held.src1.tag == cdb.tag);
    assign wake2 = cdb.valid && !held.src2.ready && (held.src2.tag == cdb.tag);

    assign ready_to_issue = busy && held.src1.ready && held.src2.ready;
    assign entry_out      = held;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= 1'b0;
        end else if (write) begin
            busy <= 1'b1;
        end else if (grant) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            held <= entry_in;
        end else begin
            if (wake1) begin
                held.src1.ready <= 1'b1;
                held.src1.data  <= cdb.data;
            end
            if (wake2) begin
                held.src2.ready <= 1'b1;
                held.src2.data  <= cdb.data;
            end
        end
    end

endmodule

// ==== rs/alu_issue.sv ====
`timescale 1ns/1ps

module alu_issue (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic [ooo_pkg::NUM_RS-1:0] slot_ready,
    input  ooo_pkg::rs_entry_t         slot_entry [ooo_pkg::NUM_RS],
    output logic [ooo_pkg::NUM_RS-1:0] grant,
    output ooo_pkg::cdb_t              cdb
);
    import ooo_pkg::*;

    rs_entry_t        sel;
    logic [XLEN-1:0]  imm_ext;
    logic [XLEN-1:0]  result;
    logic             cdb_valid_q;
    logic [TAG_W-1:0] cdb_tag_q;
    logic [XLEN-1:0]  cdb_data_q;

    // lowest ready index wins
    assign grant = slot_ready & (~slot_ready + NUM_RS'(1));

    always_comb begin
        sel = slot_entry[0];
        for (int i = 0; i < NUM_RS; i++) begin
            if (grant[i]) begin
                sel = slot_entry[i];
            end
        end
    end

    assign imm_ext = {{(XLEN - IMM_W){sel.imm[IMM_W-1]}}, sel.imm};

    always_comb begin
        case (sel.op)
            ADD:     result = sel.src1.data + sel.src2.data;
            SUB:     result = sel.src1.data - sel.src2.data;
            AND:     result = sel.src1.data & sel.src2.data;
            OR:      result = sel.src1.data | sel.src2.data;
            XOR:     result = sel.src1.data ^ sel.src2.data;
            ADDI:    result = sel.src1.data + imm_ext;
            XORI:    result = sel.src1.data ^ imm_ext;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            cdb_valid_q <= 1'b0;
        end else begin
            cdb_valid_q <= |grant;
        end
    end

    always_ff @(posedge clk) begin
        cdb_tag_q  <= sel.dest_tag;
        cdb_data_q <= result;
    end

    assign cdb = '{valid: cdb_valid_q, tag: cdb_tag_q, data: cdb_data_q};

endmodule

// ==== logic/ooo_core_slice.sv ====
`timescale 1ns/1ps

module ooo_core_slice (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             in_valid,
    input  ooo_pkg::dec_op_t in_op,
    output logic             in_ready,
    output logic             commit_valid,
    output ooo_pkg::commit_t commit_data,
    input  logic             commit_ready
);
    import ooo_pkg::*;

    logic             in_fire;
    logic             commit_fire;
    logic             rob_full;
    logic             have_free;
    logic [TAG_W-1:0] alloc_tag;
    logic [TAG_W-1:0] commit_tag;

    logic             rs1_busy;
    logic [TAG_W-1:0] rs1_tag;
    logic [XLEN-1:0]  rs1_data;
    logic             rs2_busy;
    logic [TAG_W-1:0] rs2_tag;
    logic [XLEN-1:0]  rs2_data;
    logic             lookup_done1;
    logic [XLEN-1:0]  lookup_data1;
    logic             lookup_done2;
    logic [XLEN-1:0]  lookup_data2;

    cdb_t              cdb;
    rs_entry_t         new_entry;
    rs_entry_t         slot_entry [NUM_RS];
    logic [NUM_RS-1:0] slot_write;
    logic [NUM_RS-1:0] slot_busy;
    logic [NUM_RS-1:0] slot_ready;
    logic [NUM_RS-1:0] grant;

    assign in_ready    = !rob_full && have_free && !flush;
    assign in_fire     = in_valid && in_ready;
    assign commit_fire = commit_valid && commit_ready;

    reg_rename_file reg_rename_file_inst (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .rd_rs1       (in_op.rs1),
        .rd_rs2       (in_op.rs2),
        .rs1_busy     (rs1_busy),
        .rs1_tag      (rs1_tag),
        .rs1_data     (rs1_data),
        .rs2_busy     (rs2_busy),
        .rs2_tag      (rs2_tag),
        .rs2_data     (rs2_data),
        .rename_en    (in_fire),
        .rename_rd    (in_op.rd),
        .rename_tag   (alloc_tag),
        .commit_en    (commit_fire),
        .commit_rd    (commit_data.rd),
        .commit_tag   (commit_tag),
        .commit_value (commit_data.data)
    );

    reorder_buffer reorder_buffer_inst (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .alloc_en     (in_fire),
        .alloc_rd     (in_op.rd),
        .alloc_pc     (in_op.pc),
        .full         (rob_full),
        .alloc_tag    (alloc_tag),
        .cdb          (cdb),
        .lookup_tag1  (rs1_tag),
        .lookup_done1 (lookup_done1),
        .lookup_data1 (lookup_data1),
        .lookup_tag2  (rs2_tag),
        .lookup_done2 (lookup_done2),
        .lookup_data2 (lookup_data2),
        .commit_valid (commit_valid),
        .commit_data  (commit_data),
        .commit_tag   (commit_tag),
        .commit_ready (commit_ready)
    );

    // only an accepted operation reaches a slot
    rs_dispatch rs_dispatch_inst (
        .in_valid     (in_fire),
        .in_op        (in_op),
        .alloc_tag    (alloc_tag),
        .rs1_busy     (rs1_busy),
        .rs1_tag      (rs1_tag),
        .rs1_data     (rs1_data),
        .rs2_busy     (rs2_busy),
        .rs2_tag      (rs2_tag),
        .rs2_data     (rs2_data),
        .lookup_done1 (lookup_done1),
        .lookup_data1 (lookup_data1),
        .lookup_done2 (lookup_done2),
        .lookup_data2 (lookup_data2),
        .cdb          (cdb),
        .slot_busy    (slot_busy),
        .slot_write   (slot_write),
        .entry        (new_entry),
        .have_free    (have_free)
    );

    for (genvar i = 0; i < NUM_RS; i++) begin : g_slot
        rs_slot rs_slot_inst (
            .clk            (clk),
            .rst            (rst),
            .flush          (flush),
            .write          (slot_write[i]),
            .entry_in       (new_entry),
            .cdb            (cdb),
            .grant          (grant[i]),
            .busy           (slot_busy[i]),
            .ready_to_issue (slot_ready[i]),
            .entry_out      (slot_entry[i])
        );
    end

    alu_issue alu_issue_inst (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .slot_ready (slot_ready),
        .slot_entry (slot_entry),
        .grant      (grant),
        .cdb        (cdb)
    );

endmodule

// ==== sim/ooo_core_slice_chk.sv ====
`timescale 1ns/1ps

module ooo_core_slice_chk (
    input logic                       clk,
    input logic                       rst,
    input logic                       flush,
    input logic                       in_ready,
    input logic                       commit_valid,
    input logic                       commit_ready,
    input ooo_pkg::commit_t           commit_data,
    input logic                       cdb_valid,
    input logic [ooo_pkg::NUM_RS-1:0] slot_busy
);
    import ooo_pkg::*;

    int fail_count;

    initial fail_count = 0;

    // a stalled commit keeps its payload
    commit_hold: assert property (@(posedge clk) disable iff (rst)
        (commit_valid && !commit_ready && !flush) |=> (commit_valid && $stable(commit_data)))
    else begin
        $error("commit payload changed or dropped while the commit port was stalled");
        fail_count++;
    end

    reset_state: assert property (@(posedge clk)
        $fell(rst) |-> (in_ready && !commit_valid && !cdb_valid && (slot_busy == '0)))
    else begin
        $error("outputs after reset are not idle");
        fail_count++;
    end

    flush_blocks_intake: assert property (@(posedge clk) disable iff (rst)
        flush |-> !in_ready)
    else begin
        $error("in_ready was high during a flush");
        fail_count++;
    end

    handshake_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(in_ready) && !$isunknown(commit_valid))
    else begin
        $error("handshake outputs are unknown");
        fail_count++;
    end

endmodule

bind ooo_core_slice ooo_core_slice_chk chk_inst (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .in_ready     (in_ready),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit_data  (commit_data),
    .cdb_valid    (cdb.valid),
    .slot_busy    (slot_busy)
);

// ==== sim/ooo_core_slice_tb.sv ====
`timescale 1ns/1ps

module ooo_core_slice_tb;
    import ooo_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int DRAIN_LIMIT = 400;

    logic    clk;
    logic    rst;
    logic    flush;
    logic    in_valid;
    dec_op_t in_op;
    logic    in_ready;
    logic    commit_valid;
    commit_t commit_data;
    logic    commit_ready;

    logic [31:0]     lfsr;
    dec_op_t         pending_q [$];
    logic [XLEN-1:0] arch [NUM_REGS];
    logic [XLEN-1:0] next_pc;
    logic            offer_done;
    logic            saw_stall;
    logic            drained;
    int              errors;
    int              commits;
    int              wait_cycles;

    ooo_core_slice ooo_core_slice_inst (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_ready     (in_ready),
        .commit_valid (commit_valid),
        .commit_data  (commit_data),
        .commit_ready (commit_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr[0]};
            if (lfsr[0]) begin
                lfsr = {1'b0, lfsr[31:1]} ^ 32'hD000_0001;
            end else begin
                lfsr = {1'b0, lfsr[31:1]};
            end
        end
        return val;
    endfunction

    // only x0 to x7 so that dependencies stay dense
    function automatic dec_op_t random_op();
        dec_op_t op;
        op.op  = alu_op_e'(3'(take_bits(3) % 7));
        op.rd  = REG_W'(take_bits(3));
        op.rs1 = REG_W'(take_bits(3));
        op.rs2 = REG_W'(take_bits(3));
        op.imm = IMM_W'(take_bits(IMM_W));
        op.pc  = next_pc;
        return op;
    endfunction

    function automatic logic [XLEN-1:0] model_result(input dec_op_t op);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm;
        a   = arch[op.rs1];
        b   = arch[op.rs2];
        imm = XLEN'($signed(op.imm));
        case (op.op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            ADDI:    return a + imm;
            XORI:    return a ^ imm;
            default: return '0;
        endcase
    endfunction

    task automatic check_commit();
        dec_op_t         exp_op;
        logic [XLEN-1:0] exp_val;
        assert (pending_q.size() > 0) else begin
            errors++;
            $display("commit at %0t arrived with no accepted operation outstanding", $time);
        end
        if (pending_q.size() > 0) begin
            exp_op  = pending_q.pop_front();
            exp_val = model_result(exp_op);
            assert ((commit_data.pc == exp_op.pc) && (commit_data.rd == exp_op.rd)) else begin
                errors++;
                $display("CHECK FAILED at %0t: commit pc %h rd %0d, expected pc %h rd %0d",
                         $time, commit_data.pc, commit_data.rd, exp_op.pc, exp_op.rd);
            end
            assert (commit_data.data == exp_val) else begin
                errors++;
                $display("CHECK FAILED at %0t: pc %h committed %h, expected %h",
                         $time, exp_op.pc, commit_data.data, exp_val);
            end
            if (exp_op.rd != '0) begin
                arch[exp_op.rd] = exp_val;
            end
            commits++;
        end
    endtask

    // drive at the falling edge, then look at what the next rising edge will see
    task automatic run_cycle(input logic do_flush, input logic hold_commit, input logic allow_new);
        @(negedge clk);
        if (!in_valid || offer_done) begin
            in_valid = 1'b0;
            if (allow_new && (take_bits(2) != 0)) begin
                in_valid = 1'b1;
                in_op    = random_op();
            end
        end
        flush        = do_flush;
        commit_ready = hold_commit ? 1'b0 : (take_bits(3) != 0);
        #1;
        offer_done = in_valid && in_ready;
        if (offer_done) begin
            pending_q.push_back(in_op);
            next_pc = next_pc + 4;
        end
        if (hold_commit && !in_ready) begin
            saw_stall = 1'b1;
        end
        if (commit_valid && commit_ready) begin
            check_commit();
        end
        if (do_flush) begin
            pending_q.delete();
        end
    endtask

    initial begin
        lfsr         = 32'd70827;
        rst          = 1'b1;
        flush        = 1'b0;
        in_valid     = 1'b0;
        in_op        = '0;
        commit_ready = 1'b0;
        next_pc      = '0;
        offer_done   = 1'b0;
        saw_stall    = 1'b0;
        drained      = 1'b0;
        errors       = 0;
        commits      = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            arch[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 300; i++) begin
            run_cycle(1'b0, 1'b0, 1'b1);
        end
        // long commit stall fills the rob
        for (int i = 0; i < 24; i++) begin
            run_cycle(1'b0, 1'b1, 1'b1);
        end
        assert (saw_stall) else begin
            errors++;
            $display("in_ready never dropped while commits were held back");
        end
        for (int r = 0; r < 3; r++) begin
            for (int i = 0; i < 60; i++) begin
                run_cycle(1'b0, 1'b0, 1'b1);
            end
            run_cycle(1'b1, 1'b0, 1'b1);
        end
        for (int i = 0; i < 200; i++) begin
            run_cycle(1'b0, 1'b0, 1'b1);
        end

        wait_cycles = 0;
        while ((pending_q.size() != 0 || (in_valid && !offer_done)) &&
               (wait_cycles < DRAIN_LIMIT)) begin
            run_cycle(1'b0, 1'b0, 1'b0);
            wait_cycles++;
        end
        drained = (pending_q.size() == 0) && !(in_valid && !offer_done);

        $display("commits %0d, value errors %0d, assertion errors %0d",
                 commits, errors, ooo_core_slice_inst.chk_inst.fail_count);
        if (!drained) begin
            $display("timed out draining, %0d operations still pending or never accepted",
                     pending_q.size());
            $display("FAIL: see errors above");
        end else if ((errors == 0) && (ooo_core_slice_inst.chk_inst.fail_count == 0)) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== ooo_core_slice.f ====
common/ooo_pkg.sv
logic/reg_rename_file.sv
rob/reorder_buffer.sv
rs/rs_dispatch.sv
rs/rs_slot.sv
rs/alu_issue.sv
logic/ooo_core_slice.sv
sim/ooo_core_slice_chk.sv
sim/ooo_core_slice_tb.sv

// ==== Bender.yml ====
package:
  name: ooo_core_slice

sources:
  - common/ooo_pkg.sv
  - logic/reg_rename_file.sv
  - rob/reorder_buffer.sv
  - rs/rs_dispatch.sv
  - rs/rs_slot.sv
  - rs/alu_issue.sv
  - logic/ooo_core_slice.sv
  - target: simulation
    files:
      - sim/ooo_core_slice_chk.sv
      - sim/ooo_core_slice_tb.sv
